// File: source/flow_consts.svh
////////////////////
// flow stage constants
// sizes, reset levels and register map of the two-lane buffer stage
////////////////////

`ifndef FLOW_CONSTS_SVH
`define FLOW_CONSTS_SVH

// lane payload and buffer sizing
`define FLOW_DATA_WIDTH 8
`define FLOW_FIFO_DEPTH 8
`define FLOW_COUNT_WIDTH 4        // must hold 0 up to FLOW_FIFO_DEPTH inclusive

// reset values of the programmable levels, sized to the count width
`define FLOW_AF_DEFAULT 4'd6
`define FLOW_AE_DEFAULT 4'd2

// APB bus widths
`define FLOW_APB_ADDR_WIDTH 8
`define FLOW_APB_DATA_WIDTH 32

// register byte addresses
`define FLOW_REG_CTRL 8'h00       // pause bits
`define FLOW_REG_LEVELS 8'h04     // almost-full and almost-empty levels
`define FLOW_REG_STATUS 8'h08     // fifo flags of both lanes, read only
`define FLOW_REG_ERROR 8'h0C      // sticky drop bits, write one to clear

`endif

// File: source/flow_pkg.sv
////////////////////
// flow package
// types that describe the lane side of the stage, the data word and
// the flag bundle each lane fifo reports
////////////////////

`default_nettype none

`include "flow_consts.svh"

package flow_pkg;

    // one word as it travels through a lane
    typedef logic [`FLOW_DATA_WIDTH-1:0] lane_word_t;

    // flags of one lane fifo
    // the field order gives full in bit 3 and almost_empty in bit 0,
    // which is also the nibble layout the STATUS register shows
    typedef struct packed {
        logic full;             // count has reached the fifo depth
        logic empty;            // nothing stored
        logic almost_full;      // count at or above the almost-full level
        logic almost_empty;     // count at or below the almost-empty level
    } fifo_flags_t;

endpackage

`default_nettype wire

// File: source/apb_regs_pkg.sv
////////////////////
// register package
// types of the APB register side, register index and level settings
////////////////////

`default_nettype none

`include "flow_consts.svh"

package apb_regs_pkg;

    // the four registers in address order, index is paddr[3:2]
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_LEVELS = 2'd1,
        REG_STATUS = 2'd2,
        REG_ERROR  = 2'd3
    } reg_index_t;

    // level settings shared by both lane fifos
    // ae_level is declared first so it lands in bits 7:4 and af_level in 3:0,
    // matching the LEVELS register word
    typedef struct packed {
        logic [`FLOW_COUNT_WIDTH-1:0] ae_level;   // almost-empty threshold
        logic [`FLOW_COUNT_WIDTH-1:0] af_level;   // almost-full threshold
    } level_cfg_t;

endpackage

`default_nettype wire

// File: source/fifo_status_if.sv
////////////////////
// fifo status interface
// strobes from the flow controller to one lane fifo and the flags back
////////////////////

`default_nettype none

interface fifo_status_if;
    import flow_pkg::*;

    // strobes decided by the controller, sampled by the fifo at the clock edge
    logic write;
    logic read;

    // flags follow the occupancy count of the fifo
    fifo_flags_t flags;

    // the controller side looks at the flags and drives the strobes
    modport control (
        output write,
        output read,
        input  flags
    );

    // the fifo side obeys the strobes and reports its state
    modport fifo (
        input  write,
        input  read,
        output flags
    );

endinterface

`default_nettype wire

// File: source/lane_fifo.sv
////////////////////
// lane fifo
// circular buffer for one lane with an occupancy count, programmable
// almost flags and a registered output word
////////////////////

`default_nettype none

`include "flow_consts.svh"

module lane_fifo (
    input  logic                         clk,
    input  logic                         reset,       // synchronous, active low
    input  flow_pkg::lane_word_t         data_in,     // word offered by the upstream
    input  apb_regs_pkg::level_cfg_t     levels,      // thresholds from the register block
    fifo_status_if.fifo                  status,
    output flow_pkg::lane_word_t         data_out,
    output logic                         valid,
    output logic [`FLOW_COUNT_WIDTH-1:0] count
);
    import flow_pkg::*;

    localparam int DEPTH = `FLOW_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int COUNT_W = `FLOW_COUNT_WIDTH;
    localparam logic [COUNT_W-1:0] FULL_COUNT = COUNT_W'(DEPTH);

    lane_word_t       mem [DEPTH];     // storage, no reset needed
    logic [PTR_W-1:0] wr_ptr;          // next slot to fill
    logic [PTR_W-1:0] rd_ptr;          // oldest stored word
    fifo_flags_t      flags;

    // pointer step that wraps at the depth, so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            next_ptr = '0;
        end else begin
            next_ptr = ptr + 1'b1;
        end
    endfunction

    // control state
    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            if (status.write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (status.read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({status.write, status.read})
                2'b10:   count <= count + 1'b1;   // store only
                2'b01:   count <= count - 1'b1;   // drain only
                default: count <= count;          // idle, or in and out together
            endcase
            valid <= status.read;                 // one cycle per word read
        end
    end

    // data path, the output word is only meaningful while valid is high
    always_ff @(posedge clk) begin
        if (status.write) begin
            mem[wr_ptr] <= data_in;
        end
        if (status.read) begin
            data_out <= mem[rd_ptr];
        end
    end

    // flags come straight from the registered count, so they change at the
    // same edge as the count and follow a level change at once
    always_comb begin
        flags.full         = (count == FULL_COUNT);
        flags.empty        = (count == '0);
        flags.almost_full  = (count >= levels.af_level);
        flags.almost_empty = (count <= levels.ae_level);
    end

    assign status.flags = flags;

    // the controller must never push into a full buffer
    a_no_write_full: assert property (@(posedge clk) disable iff (!reset)
        !(status.write && flags.full))
        else $error("lane_fifo write strobe while full");

    // and never pop an empty one
    a_no_read_empty: assert property (@(posedge clk) disable iff (!reset)
        !(status.read && flags.empty))
        else $error("lane_fifo read strobe while empty");

endmodule

`default_nettype wire

// File: source/flow_control.sv
////////////////////
// flow controller
// write and read strobes for both lanes from the fifo flags, the upstream
// push and the downstream stop, with detection of pushes into a full lane
////////////////////

`default_nettype none

module flow_control (
    input  logic [1:0]     push,     // upstream offers a word, bit per lane
    input  logic [1:0]     stop,     // downstream refuses words, bit per lane
    input  logic [1:0]     pause,    // software hold from the CTRL register
    fifo_status_if.control lane0,
    fifo_status_if.control lane1,
    output logic [1:0]     drop      // word pushed into a full lane is thrown away
);

    // lane 0
    // a push is stored unless the buffer is full, in which case it is lost
    // and flagged so the register block can make it sticky
    always_comb begin
        lane0.write = push[0] & ~lane0.flags.full;
        drop[0]     = push[0] & lane0.flags.full;
        // forward whenever a word is waiting and nobody downstream holds the lane
        lane0.read  = ~lane0.flags.empty & ~stop[0] & ~pause[0];
    end

    // lane 1 follows the same rules on its own flags
    always_comb begin
        lane1.write = push[1] & ~lane1.flags.full;
        drop[1]     = push[1] & lane1.flags.full;
        lane1.read  = ~lane1.flags.empty & ~stop[1] & ~pause[1];
    end

    // a stored word is never also counted as a drop, checked on both lanes
    always_comb begin
        assert (!(drop[0] && lane0.write))
            else $error("flow_control lane 0 drop and write together");
        assert (!(drop[1] && lane1.write))
            else $error("flow_control lane 1 drop and write together");
    end

endmodule

`default_nettype wire

// File: source/flow_config_apb.sv
////////////////////
// flow config registers
// APB slave holding pause bits and fifo levels, the live flag status
// and the sticky per-lane drop errors
////////////////////

`default_nettype none

`include "flow_consts.svh"

module flow_config_apb (
    input  logic                            clk,
    input  logic                            reset,     // synchronous, active low
    input  logic [`FLOW_APB_ADDR_WIDTH-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`FLOW_APB_DATA_WIDTH-1:0] pwdata,
    output logic [`FLOW_APB_DATA_WIDTH-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  flow_pkg::fifo_flags_t           flags0,    // lane 0 flags for STATUS
    input  flow_pkg::fifo_flags_t           flags1,    // lane 1 flags for STATUS
    input  logic [1:0]                      drop,      // drop pulses from the controller
    output apb_regs_pkg::level_cfg_t        levels,
    output logic [1:0]                      pause,
    output logic                            error
);
    import apb_regs_pkg::*;

    reg_index_t reg_idx;      // decoded register
    logic       addr_ok;      // address is one of the four registers
    logic       access;       // access phase of a transfer
    logic       wr_en;        // write that lands on a real register
    logic [1:0] err_q;        // sticky drop bits, one per lane
    logic [1:0] err_clr;      // write-one-to-clear mask for this cycle

    // only the exact byte addresses are accepted and anything else is an error
    always_comb begin
        addr_ok = 1'b1;
        reg_idx = REG_CTRL;
        case (paddr)
            `FLOW_REG_CTRL:   reg_idx = REG_CTRL;
            `FLOW_REG_LEVELS: reg_idx = REG_LEVELS;
            `FLOW_REG_STATUS: reg_idx = REG_STATUS;
            `FLOW_REG_ERROR:  reg_idx = REG_ERROR;
            default:          addr_ok = 1'b0;
        endcase
    end

    assign access  = psel & penable;
    assign wr_en   = access & pwrite & addr_ok;
    assign err_clr = (wr_en && reg_idx == REG_ERROR) ? pwdata[1:0] : 2'b00;

    // there are no wait states and every access completes in its first cycle
    assign pready  = 1'b1;
    assign pslverr = access & ~addr_ok;

    always_ff @(posedge clk) begin
        if (!reset) begin
            pause           <= 2'b00;
            levels.af_level <= `FLOW_AF_DEFAULT;
            levels.ae_level <= `FLOW_AE_DEFAULT;
            err_q           <= 2'b00;
        end else begin
            if (wr_en) begin
                case (reg_idx)
                    REG_CTRL:   pause  <= pwdata[1:0];
                    REG_LEVELS: levels <= level_cfg_t'(pwdata[7:0]);
                    default:    ;                     // STATUS ignores writes and ERROR is below
                endcase
            end
            err_q <= (err_q & ~err_clr) | drop;       // a new drop wins over a clear
        end
    end

    assign error = |err_q;

    // read data is driven for the whole transfer so it is valid in the access cycle
    always_comb begin
        prdata = '0;
        if (psel && addr_ok) begin
            case (reg_idx)
                REG_CTRL:   prdata[1:0] = pause;
                REG_LEVELS: prdata[7:0] = levels;
                REG_STATUS: prdata[7:0] = {flags1, flags0};
                REG_ERROR:  prdata[1:0] = err_q;
            endcase
        end
    end

    // the master holds the address from setup into access
    a_paddr_stable: assert property (@(posedge clk) disable iff (!reset)
        (psel && !penable) |=> $stable(paddr))
        else $error("flow_config_apb paddr changed between setup and access");

endmodule

`default_nettype wire

// File: source/flow_stage.sv
////////////////////
// flow stage top
// two buffered lanes with flow control and an APB register block
////////////////////

`default_nettype none

`include "flow_consts.svh"

module flow_stage (
    input  logic                            clk,
    input  logic                            reset,          // synchronous, active low
    // upstream side
    input  logic                            push_0,
    input  flow_pkg::lane_word_t            data_in_0,
    input  logic                            push_1,
    input  flow_pkg::lane_word_t            data_in_1,
    // downstream side
    input  logic                            stop_0,
    input  logic                            stop_1,
    output logic                            valid_0,
    output flow_pkg::lane_word_t            data_out_0,
    output logic                            valid_1,
    output flow_pkg::lane_word_t            data_out_1,
    // flags reported back to the upstream stage
    output logic                            almost_full_0,
    output logic                            almost_full_1,
    output logic                            almost_empty_0,
    output logic                            almost_empty_1,
    output logic                            full_0,
    output logic                            full_1,
    output logic                            error,          // any sticky drop bit set
    // APB
    input  logic [`FLOW_APB_ADDR_WIDTH-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`FLOW_APB_DATA_WIDTH-1:0] pwdata,
    output logic [`FLOW_APB_DATA_WIDTH-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr
);

    apb_regs_pkg::level_cfg_t levels;     // shared by both fifos
    logic [1:0]               pause;
    logic [1:0]               drop;

    fifo_status_if lane0_if ();
    fifo_status_if lane1_if ();

    // occupancy counts stay internal, software sees only the flags
    lane_fifo i_lane_fifo_0 (
        .clk      (clk),
        .reset    (reset),
        .data_in  (data_in_0),
        .levels   (levels),
        .status   (lane0_if.fifo),
        .data_out (data_out_0),
        .valid    (valid_0),
        .count    ()
    );

    lane_fifo i_lane_fifo_1 (
        .clk      (clk),
        .reset    (reset),
        .data_in  (data_in_1),
        .levels   (levels),
        .status   (lane1_if.fifo),
        .data_out (data_out_1),
        .valid    (valid_1),
        .count    ()
    );

    flow_control i_flow_control (
        .push  ({push_1, push_0}),
        .stop  ({stop_1, stop_0}),
        .pause (pause),
        .lane0 (lane0_if.control),
        .lane1 (lane1_if.control),
        .drop  (drop)
    );

    flow_config_apb i_flow_config_apb (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .flags0  (lane0_if.flags),
        .flags1  (lane1_if.flags),
        .drop    (drop),
        .levels  (levels),
        .pause   (pause),
        .error   (error)
    );

    // flag breakout toward the upstream stage
    assign almost_full_0  = lane0_if.flags.almost_full;
    assign almost_full_1  = lane1_if.flags.almost_full;
    assign almost_empty_0 = lane0_if.flags.almost_empty;
    assign almost_empty_1 = lane1_if.flags.almost_empty;
    assign full_0         = lane0_if.flags.full;
    assign full_1         = lane1_if.flags.full;

endmodule

`default_nettype wire

// File: bench/flow_stage_tb.sv
////////////////////
// flow stage testbench
// directed tests against a per-lane scoreboard with reference queues,
// APB register accesses and a watchdog
////////////////////

`default_nettype none

`include "flow_consts.svh"

module flow_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import flow_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int DEPTH = `FLOW_FIFO_DEPTH;
    localparam int DRAIN_LIMIT = 40;                 // cycles allowed to empty both lanes
    // cycle budgets of the six tests with their drains
    localparam int BUDGET_TOTAL = 20 + 100 + 60 + 70 + 60 + 80;

    logic        clk;
    logic        reset;
    logic        push_0;
    logic        push_1;
    logic        stop_0;
    logic        stop_1;
    lane_word_t  data_in_0;
    lane_word_t  data_in_1;
    lane_word_t  data_out_0;
    lane_word_t  data_out_1;
    logic        valid_0;
    logic        valid_1;
    logic        almost_full_0;
    logic        almost_full_1;
    logic        almost_empty_0;
    logic        almost_empty_1;
    logic        full_0;
    logic        full_1;
    logic        error;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // expected state of both lanes and of the register block
    lane_word_t  ref_q [2][$];       // words accepted but not yet seen on the output
    int          model_cnt [2];      // expected occupancy after the last edge
    int          words_out [2];      // words seen leaving each lane on valid
    logic [1:0]  exp_valid;          // reads decided for the coming edge
    logic [1:0]  err_model;          // expected sticky bits
    logic [1:0]  drop_last;          // drops decided for the coming edge
    logic [1:0]  pause_model;
    logic [7:0]  levels_model;       // ae in 7:4, af in 3:0
    int          err_count;
    int          check_count;
    int          tests_run;
    logic [31:0] lcg_state;

    flow_stage i_flow_stage (
        .clk            (clk),
        .reset          (reset),
        .push_0         (push_0),
        .data_in_0      (data_in_0),
        .push_1         (push_1),
        .data_in_1      (data_in_1),
        .stop_0         (stop_0),
        .stop_1         (stop_1),
        .valid_0        (valid_0),
        .data_out_0     (data_out_0),
        .valid_1        (valid_1),
        .data_out_1     (data_out_1),
        .almost_full_0  (almost_full_0),
        .almost_full_1  (almost_full_1),
        .almost_empty_0 (almost_empty_0),
        .almost_empty_1 (almost_empty_1),
        .full_0         (full_0),
        .full_1         (full_1),
        .error          (error),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                       // 4 ns period
    end

    // next pseudo random word from the upper bits of the state, which mix best
    function automatic lane_word_t next_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // flags a lane must show at a given occupancy in the order full, empty, af, ae
    function automatic logic [3:0] expected_flags(input int cnt);
        logic [3:0] f;
        f[3] = (cnt == DEPTH);
        f[2] = (cnt == 0);
        f[1] = (cnt >= int'(levels_model[3:0]));
        f[0] = (cnt <= int'(levels_model[7:4]));
        return f;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("Error %0.1f ns: %s is 0x%0h, expected 0x%0h", $realtime, what, got, exp);
            err_count++;
        end
    endtask

    // outputs settle at the rising edge, so the falling edge sees them stable
    always @(negedge clk) begin : scoreboard
        logic [1:0] push_v;
        logic [1:0] stop_v;
        logic [1:0] valid_v;
        logic [2:0] flag_v [2];
        lane_word_t din [2];
        lane_word_t dout [2];
        lane_word_t head;
        logic [3:0] f;
        logic [1:0] drop_v;
        logic       wr;
        logic       rd;
        if (reset) begin
            push_v = {push_1, push_0};
            stop_v = {stop_1, stop_0};
            valid_v = {valid_1, valid_0};
            flag_v[0] = {full_0, almost_full_0, almost_empty_0};
            flag_v[1] = {full_1, almost_full_1, almost_empty_1};
            din[0] = data_in_0;
            din[1] = data_in_1;
            dout[0] = data_out_0;
            dout[1] = data_out_1;
            check_value("error", 32'(error), 32'(|err_model));
            for (int l = 0; l < 2; l++) begin
                f = expected_flags(model_cnt[l]);
                check_value($sformatf("lane %0d flags", l), 32'(flag_v[l]),
                            32'({f[3], f[1], f[0]}));
                check_value($sformatf("lane %0d valid", l), 32'(valid_v[l]),
                            32'(exp_valid[l]));
                if (valid_v[l]) begin
                    words_out[l]++;                        // counted from the DUT output
                end
                if (exp_valid[l]) begin
                    head = ref_q[l].pop_front();           // oldest word leaves first
                    if (valid_v[l]) begin
                        check_value($sformatf("lane %0d data", l), 32'(dout[l]), 32'(head));
                    end
                end
                // what the coming edge does to this lane
                wr = push_v[l] && (model_cnt[l] < DEPTH);
                drop_v[l] = push_v[l] && (model_cnt[l] == DEPTH);
                rd = (model_cnt[l] > 0) && !stop_v[l] && !pause_model[l];
                if (wr) begin
                    ref_q[l].push_back(din[l]);
                end
                exp_valid[l] = rd;
                model_cnt[l] = model_cnt[l] + int'(wr) - int'(rd);
            end
            err_model = err_model | drop_v;                // shows on error after the edge
            drop_last = drop_v;
        end
    end

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        #1;
        paddr = addr;                                      // setup phase
        pwrite = 1'b0;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;                                    // access phase without wait states
        #0.5;
        data = prdata;
        err = pslverr;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        @(posedge clk);
        #1;
        paddr = addr;
        pwrite = 1'b1;
        pwdata = data;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #0.5;
        err = pslverr;
        @(posedge clk);                                    // the write lands here
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        case (addr)
            `FLOW_REG_CTRL:   pause_model = data[1:0];
            `FLOW_REG_LEVELS: levels_model = data[7:0];
            `FLOW_REG_ERROR:  err_model = (err_model & ~data[1:0]) | drop_last;
            default:          ;                            // STATUS and bad addresses change nothing
        endcase
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_value({what, " read"}, data, exp);
        check_value({what, " pslverr"}, 32'(err), 32'd0);
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((model_cnt[0] != 0 || model_cnt[1] != 0 || exp_valid != 2'b00)
               && n < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= DRAIN_LIMIT) begin
            $display("Lanes still held words after %0d cycles", DRAIN_LIMIT);
            err_count++;
        end
    endtask

    // lane 0 is held by stop and filled to the brim while the output stays quiet
    task automatic fill_lane_0();
        stop_0 = 1'b1;
        repeat (DEPTH) begin
            @(posedge clk);
            #1;
            check_value("valid_0 while stopped", 32'(valid_0), 32'd0);
            push_0 = 1'b1;
            data_in_0 = next_word();
        end
        @(posedge clk);
        #1;
        push_0 = 1'b0;
        check_value("full_0 after filling", 32'(full_0), 32'd1);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        $display("%s finished with %0d errors", name, err_count - errs_before);
    endtask

    task automatic reset_defaults();
        int errs;
        errs = err_count;
        check_value("valid_0", 32'(valid_0), 32'd0);
        check_value("valid_1", 32'(valid_1), 32'd0);
        check_value("error", 32'(error), 32'd0);
        check_value("pslverr", 32'(pslverr), 32'd0);
        check_value("pready", 32'(pready), 32'd1);
        read_expect(`FLOW_REG_LEVELS, 32'h26, "LEVELS");   // af 6 and ae 2
        read_expect(`FLOW_REG_STATUS, 32'h55, "STATUS");   // empty and almost empty twice
        finish_test("reset defaults", errs);
    endtask

    task automatic pass_through();
        int         errs;
        int         lat;
        lane_word_t w;
        errs = err_count;
        push_0 = 1'b1;                                     // one word into the empty lane 0
        data_in_0 = next_word();
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            push_0 = 1'b0;
            lat++;
        end while (!valid_0 && lat < 10);
        check_value("push to valid cycles", 32'(lat), 32'd2);
        repeat (40) begin
            @(posedge clk);
            #1;
            w = next_word();
            push_0 = w[7];
            data_in_0 = next_word();
            w = next_word();
            push_1 = w[7];
            data_in_1 = next_word();
        end
        @(posedge clk);
        #1;
        push_0 = 1'b0;
        push_1 = 1'b0;
        wait_drained();
        finish_test("pass through", errs);
    endtask

    task automatic back_pressure();
        int errs;
        int out0;
        errs = err_count;
        out0 = words_out[0];
        fill_lane_0();
        repeat (3) begin
            @(posedge clk);
            #1;
            check_value("valid_0 while full and stopped", 32'(valid_0), 32'd0);
        end
        stop_0 = 1'b0;
        wait_drained();
        check_value("words out of lane 0", 32'(words_out[0] - out0), 32'(DEPTH));
        finish_test("back pressure", errs);
    endtask

    task automatic overflow_drop();
        int          errs;
        int          out0;
        logic        err;
        errs = err_count;
        out0 = words_out[0];
        fill_lane_0();
        push_0 = 1'b1;                                     // the ninth word is never stored
        data_in_0 = next_word();
        @(posedge clk);
        #1;
        push_0 = 1'b0;
        check_value("error after overflow", 32'(error), 32'd1);
        read_expect(`FLOW_REG_ERROR, 32'h1, "ERROR");
        stop_0 = 1'b0;
        wait_drained();
        check_value("words out after overflow", 32'(words_out[0] - out0), 32'(DEPTH));
        apb_write(`FLOW_REG_ERROR, 32'h1, err);
        check_value("ERROR clear pslverr", 32'(err), 32'd0);
        check_value("error after clear", 32'(error), 32'd0);
        finish_test("overflow", errs);
    endtask

    task automatic level_tracking();
        int   errs;
        logic err;
        errs = err_count;
        apb_write(`FLOW_REG_LEVELS, 32'h13, err);          // af 3 and ae 1
        check_value("LEVELS write pslverr", 32'(err), 32'd0);
        stop_0 = 1'b1;
        push_0 = 1'b1;
        data_in_0 = next_word();
        for (int n = 1; n <= 5; n++) begin
            @(posedge clk);
            #1;
            check_value("almost_full_0", 32'(almost_full_0), 32'(n >= 3));
            check_value("almost_empty_0", 32'(almost_empty_0), 32'(n <= 1));
            data_in_0 = next_word();
            if (n == 5) begin
                push_0 = 1'b0;
            end
        end
        stop_0 = 1'b0;
        wait_drained();
        apb_write(`FLOW_REG_LEVELS, 32'h26, err);          // back to the reset levels
        finish_test("levels", errs);
    endtask

    task automatic pause_and_bus_error();
        int          errs;
        int          out1;
        logic [31:0] data;
        logic        err;
        errs = err_count;
        out1 = words_out[1];
        apb_write(`FLOW_REG_CTRL, 32'h2, err);             // hold lane 1 only
        push_1 = 1'b1;
        repeat (3) begin
            data_in_1 = next_word();
            @(posedge clk);
            #1;
        end
        push_1 = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1;
            check_value("valid_1 while paused", 32'(valid_1), 32'd0);
        end
        read_expect(`FLOW_REG_CTRL, 32'h2, "CTRL");
        read_expect(`FLOW_REG_STATUS,
                    32'({expected_flags(model_cnt[1]), expected_flags(model_cnt[0])}), "STATUS");
        apb_read(8'h10, data, err);
        check_value("pslverr on bad read", 32'(err), 32'd1);
        apb_write(8'h10, 32'hFF, err);
        check_value("pslverr on bad write", 32'(err), 32'd1);
        read_expect(`FLOW_REG_CTRL, 32'h2, "CTRL after bad write");
        read_expect(`FLOW_REG_LEVELS, 32'h26, "LEVELS after bad write");
        apb_write(`FLOW_REG_CTRL, 32'h0, err);
        wait_drained();
        check_value("words out of lane 1", 32'(words_out[1] - out1), 32'd3);
        finish_test("pause and bus error", errs);
    endtask

    initial begin
        reset = 1'b0;
        push_0 = 1'b0;
        push_1 = 1'b0;
        stop_0 = 1'b0;
        stop_1 = 1'b0;
        data_in_0 = '0;
        data_in_1 = '0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        model_cnt[0] = 0;
        model_cnt[1] = 0;
        words_out[0] = 0;
        words_out[1] = 0;
        exp_valid = 2'b00;
        err_model = 2'b00;
        drop_last = 2'b00;
        pause_model = 2'b00;
        levels_model = 8'h26;
        err_count = 0;
        check_count = 0;
        tests_run = 0;
        lcg_state = 32'd62703;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b1;
        reset_defaults();
        pass_through();
        back_pressure();
        overflow_drop();
        level_tracking();
        pause_and_bus_error();
        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #((BUDGET_TOTAL + RESET_CYCLES) * 4 + 400);
        $display("Watchdog expired, tests did not finish within %0d cycles", BUDGET_TOTAL);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+source
source/flow_pkg.sv
source/apb_regs_pkg.sv
source/fifo_status_if.sv
source/lane_fifo.sv
source/flow_control.sv
source/flow_config_apb.sv
source/flow_stage.sv
bench/flow_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the flow stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module flow_stage_tb \
    -o flow_stage_sim

./obj_dir/flow_stage_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
